// ==== common/m_ext_cfg.svh ====
// M extension configuration

`ifndef M_EXT_CFG_SVH
`define M_EXT_CFG_SVH

// Operand and result width
`define XLEN 32

// Issue to writeback for a divide, XLEN steps plus fix-up plus strobe
`define DIV_LATENCY (`XLEN + 2)

// Register stages in the multiplier
`define MUL_STAGES 2

`endif

// ==== common/m_ext_pkg.sv ====
// M extension types

`include "m_ext_cfg.svh"

package m_ext_pkg;

    typedef logic [4:0] rd_t;  // Destination register number

    // Encodings follow funct3[1:0] of RV32M
    typedef enum logic [1:0] {
        MUL    = 2'd0,
        MULH   = 2'd1,
        MULHSU = 2'd2,
        MULHU  = 2'd3
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV  = 2'd0,
        DIVU = 2'd1,
        REM  = 2'd2,
        REMU = 2'd3
    } div_op_e;

    // From the issue stage
    typedef struct packed {
        logic              valid;
        logic [2:0]        funct3;
        logic [`XLEN-1:0]  rs1;
        logic [`XLEN-1:0]  rs2;
        rd_t               rd;
    } m_req_s;

    typedef struct packed {
        logic              valid;
        mul_op_e           op;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
    } mul_issue_s;

    typedef struct packed {
        logic              valid;
        div_op_e           op;
        logic [`XLEN-1:0]  a;   // Dividend
        logic [`XLEN-1:0]  b;   // Divisor
    } div_issue_s;

    typedef struct packed {
        logic              valid;
        rd_t               rd;
        logic [`XLEN-1:0]  result;
    } m_wb_s;

endpackage

// ==== m_unit/mul_pipe.sv ====
// Two-stage multiplier

`include "m_ext_cfg.svh"

module mul_pipe #(
    parameter type tag_t = m_ext_pkg::rd_t
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  m_ext_pkg::mul_issue_s  issue,
    input  tag_t                   tag,
    output m_ext_pkg::m_wb_s       wb
);

    logic [2*`XLEN-1:0] prod_uu;
    logic [2*`XLEN-1:0] prod_ss;
    logic [2*`XLEN-1:0] prod_su;
    logic [`XLEN-1:0]   res_d;

    logic               s1_valid;
    tag_t               s1_tag;
    logic [`XLEN-1:0]   s1_res;
    logic               s2_valid;
    tag_t               s2_tag;
    logic [`XLEN-1:0]   s2_res;

    always_comb begin
        prod_uu = issue.a * issue.b;
        prod_ss = $signed(issue.a) * $signed(issue.b);
        // Extra bit keeps rs2 unsigned inside a signed multiply
        prod_su = $signed({issue.a[`XLEN-1], issue.a}) * $signed({1'b0, issue.b});
    end

    always_comb begin
        case (issue.op)
            m_ext_pkg::MUL:    res_d = prod_ss[`XLEN-1:0];
            m_ext_pkg::MULH:   res_d = prod_ss[2*`XLEN-1:`XLEN];
            m_ext_pkg::MULHSU: res_d = prod_su[2*`XLEN-1:`XLEN];
            default:           res_d = prod_uu[2*`XLEN-1:`XLEN];  // MULHU
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid;
        end
    end

    // Payload stages
    always_ff @(posedge clk) begin
        s1_tag <= tag;
        s1_res <= res_d;
        s2_tag <= s1_tag;
        s2_res <= s1_res;
    end

    assign wb = '{valid: s2_valid, rd: s2_tag, result: s2_res};

    // Every issue comes back after the fixed depth
    mul_latency_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue.valid |-> ##(`MUL_STAGES) wb.valid
    );

endmodule

// ==== m_unit/div_iter.sv ====
// Iterative restoring divider

`include "m_ext_cfg.svh"

module div_iter #(
    parameter type tag_t = m_ext_pkg::rd_t
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  m_ext_pkg::div_issue_s  issue,
    input  tag_t                   tag,
    output logic                   busy,
    output m_ext_pkg::m_wb_s       wb
);

    localparam int CNT_W = $clog2(`DIV_LATENCY);
    localparam logic [CNT_W-1:0] FIX_CNT  = CNT_W'(`XLEN);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`DIV_LATENCY - 1);
    localparam logic [`XLEN-1:0] MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};

    // Control state
    logic               run_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               wb_valid_q;

    // Operands and partial results
    m_ext_pkg::div_op_e op_q;
    tag_t               tag_q;
    logic [`XLEN-1:0]   a_q;
    logic [`XLEN-1:0]   dvs_q;
    logic [`XLEN-1:0]   quo_q;
    logic [`XLEN-1:0]   rem_q;
    logic [`XLEN-1:0]   res_q;
    logic               q_neg_q;
    logic               r_neg_q;
    logic               zero_q;
    logic               ovf_q;

    logic               is_signed;
    logic [`XLEN-1:0]   a_mag;
    logic [`XLEN-1:0]   b_mag;
    logic [`XLEN:0]     shifted;
    logic [`XLEN:0]     diff;
    logic [`XLEN-1:0]   q_fix;
    logic [`XLEN-1:0]   r_fix;

    assign is_signed = (issue.op == m_ext_pkg::DIV) || (issue.op == m_ext_pkg::REM);
    assign a_mag = (is_signed && issue.a[`XLEN-1]) ? -issue.a : issue.a;
    assign b_mag = (is_signed && issue.b[`XLEN-1]) ? -issue.b : issue.b;

    // One restoring step, borrow shows in the top bit
    assign shifted = {rem_q, quo_q[`XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    always_comb begin
        q_fix = q_neg_q ? -quo_q : quo_q;
        r_fix = r_neg_q ? -rem_q : rem_q;
        if (zero_q) begin
            q_fix = '1;
            r_fix = a_q;
        end else if (ovf_q) begin
            q_fix = a_q;
            r_fix = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q      <= 1'b0;
            cnt_q      <= '0;
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= 1'b0;
            if (issue.valid) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (run_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == LAST_CNT) begin
                    run_q      <= 1'b0;
                    wb_valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            op_q    <= issue.op;
            tag_q   <= tag;
            a_q     <= issue.a;
            dvs_q   <= b_mag;
            quo_q   <= a_mag;  // Dividend shifts out as quotient shifts in
            rem_q   <= '0;
            q_neg_q <= is_signed && (issue.a[`XLEN-1] ^ issue.b[`XLEN-1]);
            r_neg_q <= is_signed && issue.a[`XLEN-1];
            zero_q  <= (issue.b == '0);
            ovf_q   <= is_signed && (issue.a == MOST_NEG) && (issue.b == '1);
        end else if (run_q && cnt_q < FIX_CNT) begin
            if (!diff[`XLEN]) begin
                rem_q <= diff[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b0};
            end
        end else if (run_q && cnt_q == FIX_CNT) begin
            res_q <= (op_q == m_ext_pkg::REM || op_q == m_ext_pkg::REMU) ? r_fix : q_fix;
        end
    end

    // Held through the strobe cycle
    assign busy = run_q | wb_valid_q;
    assign wb   = '{valid: wb_valid_q, rd: tag_q, result: res_q};

    no_issue_when_busy_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue.valid |-> !busy
    );

endmodule

// ==== rtl/m_dispatch.sv ====
// Multiply/divide request dispatch

`include "m_ext_cfg.svh"

module m_dispatch (
    input  m_ext_pkg::m_req_s      req,
    input  logic                   div_busy,
    input  m_ext_pkg::m_wb_s       mul_wb,
    input  m_ext_pkg::m_wb_s       div_wb,
    output m_ext_pkg::mul_issue_s  mul_issue,
    output m_ext_pkg::div_issue_s  div_issue,
    output m_ext_pkg::rd_t         tag,
    output logic                   stall,
    output m_ext_pkg::m_wb_s       wb
);

    logic accept;
    logic is_div;

    // Only the divider holds the issue stage
    assign stall  = div_busy;
    assign accept = req.valid && !stall;
    assign is_div = req.funct3[2];  // funct3 4..7

    always_comb begin
        mul_issue.valid = accept && !is_div;
        mul_issue.op    = m_ext_pkg::mul_op_e'(req.funct3[1:0]);
        mul_issue.a     = req.rs1;
        mul_issue.b     = req.rs2;
    end

    always_comb begin
        div_issue.valid = accept && is_div;
        div_issue.op    = m_ext_pkg::div_op_e'(req.funct3[1:0]);
        div_issue.a     = req.rs1;
        div_issue.b     = req.rs2;
    end

    assign tag = req.rd;  // Shared, each unit samples it on its own issue

    // Issue rules keep the strobes apart
    assign wb = div_wb.valid ? div_wb : mul_wb;

    wb_no_collision_a: assert final (!(mul_wb.valid === 1'b1 && div_wb.valid === 1'b1));

endmodule

// ==== rtl/m_unit_top.sv ====
// RV32M multiply/divide unit

`include "m_ext_cfg.svh"

module m_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  m_ext_pkg::m_req_s  req,
    output logic               stall,
    output m_ext_pkg::m_wb_s   wb
);

    m_ext_pkg::mul_issue_s mul_issue;
    m_ext_pkg::div_issue_s div_issue;
    m_ext_pkg::rd_t        tag;
    m_ext_pkg::m_wb_s      mul_wb;
    m_ext_pkg::m_wb_s      div_wb;
    logic                  div_busy;

    m_dispatch u_dispatch (
        .req       (req),
        .div_busy  (div_busy),
        .mul_wb    (mul_wb),
        .div_wb    (div_wb),
        .mul_issue (mul_issue),
        .div_issue (div_issue),
        .tag       (tag),
        .stall     (stall),
        .wb        (wb)
    );

    mul_pipe #(.tag_t(m_ext_pkg::rd_t)) u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (mul_issue),
        .tag   (tag),
        .wb    (mul_wb)
    );

    div_iter #(.tag_t(m_ext_pkg::rd_t)) u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (div_issue),
        .tag   (tag),
        .busy  (div_busy),
        .wb    (div_wb)
    );

endmodule

// ==== bench/m_unit_tb.sv ====
// M unit testbench

`include "m_ext_cfg.svh"

module m_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACCEPT_LIMIT = 100;  // Cycles a request may be held
    localparam int DRAIN_LIMIT  = 200;

    typedef struct packed {
        m_ext_pkg::rd_t    rd;
        logic [`XLEN-1:0]  result;
        logic [31:0]       due;      // Cycle of the expected strobe
    } exp_item_s;

    logic                clk;
    logic                rst_n;
    m_ext_pkg::m_req_s   req;
    logic                stall;
    m_ext_pkg::m_wb_s    wb;

    exp_item_s           sb_q[$];
    logic [31:0]         cycle = '0;
    logic [31:0]         div_acc = 32'd1;  // Stall window of the last divide
    logic [31:0]         div_due = 32'd0;
    int                  value_errs = 0;
    int                  other_errs = 0;
    int                  sent_cnt = 0;
    int                  wb_cnt = 0;

    m_unit_top dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .stall (stall),
        .wb    (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // RV32M result from funct3 and operands
    function automatic logic [`XLEN-1:0] ref_result(input logic [2:0] f3,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        p;
        logic               zero;
        logic               ovf;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        sq = sa / sb;
        sr = sa % sb;
        ua = {32'b0, a};
        ub = {32'b0, b};
        zero = (b == 32'h0);
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f3)
            3'd0: p = sa * sb;
            3'd1: p = (sa * sb) >> 32;
            3'd2: p = (sa * ub) >> 32;                   // MULHSU
            3'd3: p = (ua * ub) >> 32;
            3'd4: p = zero ? 64'hffff_ffff : (ovf ? ua : sq);
            3'd5: p = zero ? 64'hffff_ffff : ua / ub;
            3'd6: p = zero ? ua : (ovf ? 64'h0 : sr);
            default: p = zero ? ua : ua % ub;            // REMU
        endcase
        return p[31:0];
    endfunction

    function automatic logic [`XLEN-1:0] rand_operand();
        case ($urandom_range(7))
            0: return 32'h8000_0000;
            1: return 32'hffff_ffff;
            2: return 32'h0;
            3: return 32'h1;
            default: return $urandom();
        endcase
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
    endtask

    // Holds the request until accepted, then records the expected writeback
    task automatic send(input logic [2:0] f3, input logic [`XLEN-1:0] a,
                        input logic [`XLEN-1:0] b, input m_ext_pkg::rd_t rd);
        int          waited;
        logic        taken;
        logic [31:0] due;
        exp_item_s   item;
        waited = 0;
        taken = 1'b0;
        due = '0;
        req = '{valid: 1'b1, funct3: f3, rs1: a, rs2: b, rd: rd};
        while (!taken && waited < ACCEPT_LIMIT) begin
            @(negedge clk);
            taken = !stall;
            if (f3[2])
                due = cycle + 1 + `DIV_LATENCY;
            else
                due = cycle + `MUL_STAGES;  // Last stage loads one edge after acceptance
            idle_cycle();
            waited++;
        end
        if (!taken) stop_on_timeout("request acceptance");
        item = '{rd: rd, result: ref_result(f3, a, b), due: due};
        sb_q.push_back(item);
        sent_cnt++;
        if (f3[2]) begin
            div_acc = due - `DIV_LATENCY;
            div_due = due;
        end
        req.valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (sb_q.size() != 0 && waited < DRAIN_LIMIT) begin
            idle_cycle();
            waited++;
        end
        if (sb_q.size() != 0) stop_on_timeout("scoreboard to drain");
    endtask

    // Scoreboard compare at the falling edge
    initial begin
        exp_item_s head;
        logic      exp_stall;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                exp_stall = (cycle >= div_acc) && (cycle <= div_due);
                assert (stall === exp_stall) else begin
                    value_errs++;
                    $display("[FAIL] %0t stall got %b exp %b", $time, stall, exp_stall);
                end
                if (sb_q.size() != 0 && sb_q[0].due < cycle) begin
                    other_errs++;
                    $display("Writeback for rd %0d never arrived", sb_q[0].rd);
                    void'(sb_q.pop_front());
                end
                if (wb.valid === 1'b1) wb_cnt++;
                if (wb.valid === 1'b1 && sb_q.size() == 0) begin
                    other_errs++;
                    $display("Writeback at %0t with no pending request", $time);
                end else if (wb.valid === 1'b1) begin
                    head = sb_q.pop_front();
                    assert (wb.rd === head.rd) else begin
                        value_errs++;
                        $display("[FAIL] %0t wb.rd got %0d exp %0d", $time, wb.rd, head.rd);
                    end
                    assert (wb.result === head.result) else begin
                        value_errs++;
                        $display("[FAIL] %0t wb.result got %h exp %h",
                                 $time, wb.result, head.result);
                    end
                    assert (cycle === head.due) else begin
                        value_errs++;
                        $display("[FAIL] %0t wb cycle got %0d exp %0d", $time, cycle, head.due);
                    end
                end else if (wb.valid !== 1'b0) begin
                    other_errs++;
                    $display("Writeback valid is unknown at %0t", $time);
                end
            end
        end
    end

    initial begin
        logic [`XLEN-1:0] mul_vals [4];
        logic [`XLEN-1:0] div_a [8];
        logic [`XLEN-1:0] div_b [8];
        void'($urandom(32'hea6));
        mul_vals = '{32'h8000_0000, 32'hffff_ffff, 32'h1, 32'h7fff_ffff};
        div_a = '{32'd7, 32'hffff_fff9, 32'd7, 32'h8000_0000,
                  32'd5, 32'h8000_0000, 32'hffff_ffff, 32'd0};
        div_b = '{32'd2, 32'd2, 32'hffff_fffe, 32'hffff_ffff,
                  32'd0, 32'd0, 32'd3, 32'd5};
        req = '0;
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Quiet after reset
        repeat (10) idle_cycle();
        assert (wb.valid === 1'b0) else begin
            value_errs++;
            $display("[FAIL] %0t wb.valid got %b exp 0", $time, wb.valid);
        end
        assert (stall === 1'b0) else begin
            value_errs++;
            $display("[FAIL] %0t stall got %b exp 0", $time, stall);
        end

        for (int op = 0; op < 4; op++)
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    send(op[2:0], mul_vals[i], mul_vals[j], m_ext_pkg::rd_t'(op * 16 + i * 4 + j));
        wait_drain();

        for (int n = 0; n < 200; n++)
            send(3'($urandom_range(3)), $urandom(), $urandom(), 5'($urandom()));
        wait_drain();

        for (int op = 4; op < 8; op++)
            for (int i = 0; i < 8; i++)
                send(op[2:0], div_a[i], div_b[i], m_ext_pkg::rd_t'(op * 8 + i));
        wait_drain();

        // Mixed traffic with idle gaps
        for (int n = 0; n < 300; n++) begin
            if ($urandom_range(3) == 0) idle_cycle();
            send(3'($urandom_range(7)), rand_operand(), rand_operand(), 5'($urandom()));
        end
        wait_drain();
        repeat (10) idle_cycle();
        assert (wb_cnt == sent_cnt) else begin
            other_errs++;
            $display("Accepted %0d requests but saw %0d writebacks", sent_cnt, wb_cnt);
        end

        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== m_unit_top.f ====
+incdir+common
common/m_ext_pkg.sv
m_unit/mul_pipe.sv
m_unit/div_iter.sv
rtl/m_dispatch.sv
rtl/m_unit_top.sv
bench/m_unit_tb.sv

// ==== Bender.yml ====
package:
  name: m_unit

sources:
  - include_dirs:
      - common
    files:
      - common/m_ext_pkg.sv
      - m_unit/mul_pipe.sv
      - m_unit/div_iter.sv
      - rtl/m_dispatch.sv
      - rtl/m_unit_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/m_unit_tb.sv
